//--- design/rob_control.sv
// dispatch tag return, commit pattern selection and commit output muxing
`timescale 1ns/10ps
`default_nettype none

module rob_control #(
	parameter int ROB_DEPTH = 16
) (
	input wire is_thread1,
	input wire inst1_load, inst2_load,
	input wire [$clog2(ROB_DEPTH)-1:0] t1_tail, t2_tail,
	input wire t1_queue_full, t2_queue_full,
	input wire t1_head_ready, t1_next_ready, t2_head_ready, t2_next_ready,
	input wire rob_types_pkg::pc_t t1_head_pc, t1_next_pc, t2_head_pc, t2_next_pc,
	input wire rob_types_pkg::pc_t t1_head_target_pc, t1_next_target_pc,
	input wire rob_types_pkg::pc_t t2_head_target_pc, t2_next_target_pc,
	input wire t1_head_is_branch, t1_next_is_branch, t2_head_is_branch, t2_next_is_branch,
	input wire t1_head_mispredict, t1_next_mispredict,
	input wire t2_head_mispredict, t2_next_mispredict,
	input wire rob_types_pkg::arch_reg_t t1_head_arn_dest, t1_next_arn_dest,
	input wire rob_types_pkg::arch_reg_t t2_head_arn_dest, t2_next_arn_dest,
	input wire rob_types_pkg::phys_reg_t t1_head_prn_dest, t1_next_prn_dest,
	input wire rob_types_pkg::phys_reg_t t2_head_prn_dest, t2_next_prn_dest,
	output logic [$clog2(ROB_DEPTH):0] inst1_rob_tag, inst2_rob_tag,
	output logic [1:0] t1_push_count, t2_push_count, t1_pop_count, t2_pop_count,
	output logic t1_flush, t2_flush,
	output logic commit1_valid, commit2_valid,
	output rob_types_pkg::pc_t commit1_pc, commit2_pc, commit1_target_pc, commit2_target_pc,
	output logic commit1_is_branch, commit2_is_branch,
	output logic commit1_mispredict, commit2_mispredict,
	output rob_types_pkg::arch_reg_t commit1_arn_dest, commit2_arn_dest,
	output rob_types_pkg::phys_reg_t commit1_prn_dest, commit2_prn_dest,
	output logic commit1_is_thread1, commit2_is_thread1,
	output logic t1_full, t2_full
);
	import rob_ctrl_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);

	dispatch_sel_e disp;
	commit_sel_e sel;
	logic [IDX_W-1:0] sel_tail;
	logic [IDX_W-1:0] sel_tail_plus1;
	logic c1_t2;		// slot 1 comes from thread 2
	logic c2_t2;		// slot 2 comes from thread 2
	logic c1_bad;
	logic c2_bad;

	// inst2 never loads alone
	always_comb
	begin
		if (inst1_load && inst2_load)
			disp = dispatch_pair;
		else if (inst1_load)
			disp = dispatch_one;
		else
			disp = dispatch_none;
	end

	assign sel_tail = is_thread1 ? t1_tail : t2_tail;
	assign sel_tail_plus1 = sel_tail + 1'b1;
	assign inst1_rob_tag = (disp != dispatch_none) ? {!is_thread1, sel_tail} : '0;
	assign inst2_rob_tag = (disp == dispatch_pair) ? {!is_thread1, sel_tail_plus1} : '0;
	assign t1_push_count = is_thread1 ? disp : 2'd0;
	assign t2_push_count = is_thread1 ? 2'd0 : disp;

	// thread 1 goes first and a mispredicted head never pairs with its own successor
	always_comb
	begin
		sel = commit_none;
		if (t1_head_ready)
		begin
			if (t1_next_ready && !(t1_head_is_branch && t1_head_mispredict))
				sel = commit_t1_pair;
			else if (t2_head_ready)
				sel = commit_t1_t2;
			else
				sel = commit_t1_one;
		end
		else if (t2_head_ready)
		begin
			if (t2_next_ready && !(t2_head_is_branch && t2_head_mispredict))
				sel = commit_t2_pair;
			else
				sel = commit_t2_one;
		end
	end

	always_comb
	begin
		case (sel)
			commit_t1_one, commit_t1_t2:
			begin
				t1_pop_count = 2'd1;
				t2_pop_count = (sel == commit_t1_t2) ? 2'd1 : 2'd0;
			end
			commit_t1_pair:
			begin
				t1_pop_count = 2'd2;
				t2_pop_count = 2'd0;
			end
			commit_t2_one:
			begin
				t1_pop_count = 2'd0;
				t2_pop_count = 2'd1;
			end
			commit_t2_pair:
			begin
				t1_pop_count = 2'd0;
				t2_pop_count = 2'd2;
			end
			default:
			begin
				t1_pop_count = 2'd0;
				t2_pop_count = 2'd0;
			end
		endcase
	end

	assign c1_t2 = (sel == commit_t2_one) || (sel == commit_t2_pair);
	assign c2_t2 = (sel == commit_t1_t2) || (sel == commit_t2_pair);
	assign commit1_valid = sel != commit_none;
	assign commit2_valid = (sel == commit_t1_pair) || c2_t2;

	assign commit1_pc = c1_t2 ? t2_head_pc : t1_head_pc;
	assign commit1_target_pc = c1_t2 ? t2_head_target_pc : t1_head_target_pc;
	assign commit1_is_branch = c1_t2 ? t2_head_is_branch : t1_head_is_branch;
	assign commit1_mispredict = c1_t2 ? t2_head_mispredict : t1_head_mispredict;
	assign commit1_arn_dest = c1_t2 ? t2_head_arn_dest : t1_head_arn_dest;
	assign commit1_prn_dest = c1_t2 ? t2_head_prn_dest : t1_head_prn_dest;
	assign commit1_is_thread1 = !c1_t2;

	// slot 2 is t1 next, t2 head in a mixed pair, or t2 next
	assign commit2_pc = !c2_t2 ? t1_next_pc :
		(sel == commit_t2_pair) ? t2_next_pc : t2_head_pc;
	assign commit2_target_pc = !c2_t2 ? t1_next_target_pc :
		(sel == commit_t2_pair) ? t2_next_target_pc : t2_head_target_pc;
	assign commit2_is_branch = !c2_t2 ? t1_next_is_branch :
		(sel == commit_t2_pair) ? t2_next_is_branch : t2_head_is_branch;
	assign commit2_mispredict = !c2_t2 ? t1_next_mispredict :
		(sel == commit_t2_pair) ? t2_next_mispredict : t2_head_mispredict;
	assign commit2_arn_dest = !c2_t2 ? t1_next_arn_dest :
		(sel == commit_t2_pair) ? t2_next_arn_dest : t2_head_arn_dest;
	assign commit2_prn_dest = !c2_t2 ? t1_next_prn_dest :
		(sel == commit_t2_pair) ? t2_next_prn_dest : t2_head_prn_dest;
	assign commit2_is_thread1 = !c2_t2;

	assign c1_bad = commit1_valid && commit1_is_branch && commit1_mispredict;
	assign c2_bad = commit2_valid && commit2_is_branch && commit2_mispredict;
	assign t1_flush = (c1_bad && !c1_t2) || (c2_bad && !c2_t2);
	assign t2_flush = (c1_bad && c1_t2) || (c2_bad && c2_t2);

	assign t1_full = t1_queue_full;
	assign t2_full = t2_queue_full;

	// the dispatch side loads slot 2 only together with slot 1
	always_comb
	begin
		a_load_order: assert final (!inst2_load || inst1_load)
			else $error("inst2 loaded without inst1");
	end

endmodule

`default_nettype wire

//--- design/rob_ctrl_pkg.sv
// commit pattern and dispatch slot selection enums
`default_nettype none

package rob_ctrl_pkg;

	// which heads retire this cycle, slot 1 first
	typedef enum logic [2:0] {
		commit_none,
		commit_t1_one,
		commit_t1_pair,
		commit_t1_t2,		// mixed pair, thread 1 in slot 1
		commit_t2_one,
		commit_t2_pair
	} commit_sel_e;

	// encoded as the number of loaded slots
	typedef enum logic [1:0] {
		dispatch_none = 2'd0,
		dispatch_one = 2'd1,
		dispatch_pair = 2'd2
	} dispatch_sel_e;

endpackage

`default_nettype wire

//--- design/rob_thread_queue.sv
// circular entry queue of one thread with completion marking and flush
`timescale 1ns/10ps
`default_nettype none

module rob_thread_queue #(
	parameter int ROB_DEPTH = 16,
	parameter int THREAD_ID = 0		// tag thread bit this queue answers to
) (
	input wire clock,
	input wire reset,
	input wire [1:0] push_count,
	input wire rob_types_pkg::pc_t inst1_pc, inst2_pc,
	input wire rob_types_pkg::arch_reg_t inst1_arn_dest, inst2_arn_dest,
	input wire rob_types_pkg::phys_reg_t inst1_prn_dest, inst2_prn_dest,
	input wire inst1_is_branch, inst2_is_branch,
	input wire fu1_executed, fu2_executed,
	input wire [$clog2(ROB_DEPTH):0] fu1_rob_tag, fu2_rob_tag,
	input wire fu1_mispredict, fu2_mispredict,
	input wire rob_types_pkg::pc_t fu1_target_pc, fu2_target_pc,
	input wire [1:0] pop_count,
	input wire flush,
	output logic [$clog2(ROB_DEPTH)-1:0] tail,
	output logic full,
	output logic head_ready, next_ready,
	output rob_types_pkg::pc_t head_pc, next_pc, head_target_pc, next_target_pc,
	output logic head_is_branch, next_is_branch, head_mispredict, next_mispredict,
	output rob_types_pkg::arch_reg_t head_arn_dest, next_arn_dest,
	output rob_types_pkg::phys_reg_t head_prn_dest, next_prn_dest
);
	import rob_types_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);
	localparam int CNT_W = IDX_W + 1;	// occupancy reaches ROB_DEPTH

	logic [IDX_W-1:0] head;
	logic [IDX_W-1:0] head_plus1;
	logic [IDX_W-1:0] tail_plus1;
	logic [IDX_W-1:0] pop_head;		// head after this cycle's retirement
	logic [CNT_W-1:0] count;
	logic [ROB_DEPTH-1:0] valid;
	logic [ROB_DEPTH-1:0] executed;
	logic [ROB_DEPTH-1:0] mispredict;
	logic [ROB_DEPTH-1:0] is_branch;
	pc_t pc_q [ROB_DEPTH];
	pc_t target_q [ROB_DEPTH];
	arch_reg_t arn_q [ROB_DEPTH];
	phys_reg_t prn_q [ROB_DEPTH];
	logic fu1_hit;
	logic fu2_hit;

	assign head_plus1 = head + 1'b1;
	assign tail_plus1 = tail + 1'b1;
	assign pop_head = head + IDX_W'(pop_count);

	// completions for the other thread or for dead entries fall through
	assign fu1_hit = fu1_executed && (fu1_rob_tag[IDX_W] == 1'(THREAD_ID))
		&& valid[fu1_rob_tag[IDX_W-1:0]];
	assign fu2_hit = fu2_executed && (fu2_rob_tag[IDX_W] == 1'(THREAD_ID))
		&& valid[fu2_rob_tag[IDX_W-1:0]];

	assign full = count > CNT_W'(ROB_DEPTH - 2);	// fewer than two free

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			head <= pop_head;
			if (flush)
			begin
				tail <= pop_head;	// drop everything younger than the branch
				count <= '0;
			end
			else
			begin
				tail <= tail + IDX_W'(push_count);
				count <= count + CNT_W'(push_count) - CNT_W'(pop_count);
			end
		end
	end

	// entry status
	always_ff @(posedge clock)
	begin
		if (reset || flush)
		begin
			valid <= '0;
			executed <= '0;
		end
		else
		begin
			if (pop_count != 2'd0)
				valid[head] <= 1'b0;
			if (pop_count == 2'd2)
				valid[head_plus1] <= 1'b0;
			if (push_count != 2'd0)
			begin
				valid[tail] <= 1'b1;
				executed[tail] <= 1'b0;
			end
			if (push_count == 2'd2)
			begin
				valid[tail_plus1] <= 1'b1;
				executed[tail_plus1] <= 1'b0;
			end
			if (fu1_hit)
				executed[fu1_rob_tag[IDX_W-1:0]] <= 1'b1;
			if (fu2_hit)
				executed[fu2_rob_tag[IDX_W-1:0]] <= 1'b1;
		end
	end

	// entry payload
	always_ff @(posedge clock)
	begin
		if (push_count != 2'd0)
		begin
			pc_q[tail] <= inst1_pc;
			arn_q[tail] <= inst1_arn_dest;
			prn_q[tail] <= inst1_prn_dest;
			is_branch[tail] <= inst1_is_branch;
		end
		if (push_count == 2'd2)
		begin
			pc_q[tail_plus1] <= inst2_pc;
			arn_q[tail_plus1] <= inst2_arn_dest;
			prn_q[tail_plus1] <= inst2_prn_dest;
			is_branch[tail_plus1] <= inst2_is_branch;
		end
		if (fu1_hit)
		begin
			mispredict[fu1_rob_tag[IDX_W-1:0]] <= fu1_mispredict;
			target_q[fu1_rob_tag[IDX_W-1:0]] <= fu1_target_pc;
		end
		if (fu2_hit)
		begin
			mispredict[fu2_rob_tag[IDX_W-1:0]] <= fu2_mispredict;
			target_q[fu2_rob_tag[IDX_W-1:0]] <= fu2_target_pc;
		end
	end

	assign head_ready = valid[head] && executed[head];
	assign head_pc = pc_q[head];
	assign head_target_pc = target_q[head];
	assign head_is_branch = is_branch[head];
	assign head_mispredict = mispredict[head];
	assign head_arn_dest = arn_q[head];
	assign head_prn_dest = prn_q[head];

	assign next_ready = valid[head_plus1] && executed[head_plus1];
	assign next_pc = pc_q[head_plus1];
	assign next_target_pc = target_q[head_plus1];
	assign next_is_branch = is_branch[head_plus1];
	assign next_mispredict = mispredict[head_plus1];
	assign next_arn_dest = arn_q[head_plus1];
	assign next_prn_dest = prn_q[head_plus1];

	// dispatch side must respect the full flag
	a_no_push_full: assert property (@(posedge clock) disable iff (reset)
		full |-> push_count == 2'd0);

	// commit selection may only retire executed entries
	a_pop_ready: assert property (@(posedge clock) disable iff (reset)
		pop_count <= 2'(head_ready) + 2'(head_ready && next_ready));

	a_count_bound: assert property (@(posedge clock) disable iff (reset)
		count <= CNT_W'(ROB_DEPTH));

endmodule

`default_nettype wire

//--- design/rob_top.sv
// top level of the two-thread reorder buffer with two thread queues and the commit control
`timescale 1ns/10ps
`default_nettype none

module rob_top #(
	parameter int ROB_DEPTH = rob_types_pkg::default_rob_depth
) (
	input wire clock,
	input wire reset,
	input wire is_thread1,
	input wire rob_types_pkg::pc_t inst1_pc, inst2_pc,
	input wire rob_types_pkg::arch_reg_t inst1_arn_dest, inst2_arn_dest,
	input wire rob_types_pkg::phys_reg_t inst1_prn_dest, inst2_prn_dest,
	input wire inst1_is_branch, inst2_is_branch,
	input wire inst1_load, inst2_load,
	input wire fu1_executed, fu2_executed,
	input wire [$clog2(ROB_DEPTH):0] fu1_rob_tag, fu2_rob_tag,
	input wire fu1_mispredict, fu2_mispredict,
	input wire rob_types_pkg::pc_t fu1_target_pc, fu2_target_pc,
	output logic [$clog2(ROB_DEPTH):0] inst1_rob_tag, inst2_rob_tag,
	output logic commit1_valid, commit2_valid,
	output rob_types_pkg::pc_t commit1_pc, commit2_pc, commit1_target_pc, commit2_target_pc,
	output logic commit1_is_branch, commit2_is_branch,
	output logic commit1_mispredict, commit2_mispredict,
	output rob_types_pkg::arch_reg_t commit1_arn_dest, commit2_arn_dest,
	output rob_types_pkg::phys_reg_t commit1_prn_dest, commit2_prn_dest,
	output logic commit1_is_thread1, commit2_is_thread1,
	output logic t1_full, t2_full
);
	import rob_types_pkg::*;

	localparam int IDX_W = $clog2(ROB_DEPTH);

	logic [IDX_W-1:0] t1_tail, t2_tail;
	logic [1:0] t1_push_count, t2_push_count, t1_pop_count, t2_pop_count;
	logic t1_flush, t2_flush, t1_queue_full, t2_queue_full;
	logic t1_head_ready, t1_next_ready, t2_head_ready, t2_next_ready;
	pc_t t1_head_pc, t1_next_pc, t2_head_pc, t2_next_pc;
	pc_t t1_head_target_pc, t1_next_target_pc, t2_head_target_pc, t2_next_target_pc;
	logic t1_head_is_branch, t1_next_is_branch, t2_head_is_branch, t2_next_is_branch;
	logic t1_head_mispredict, t1_next_mispredict, t2_head_mispredict, t2_next_mispredict;
	arch_reg_t t1_head_arn_dest, t1_next_arn_dest, t2_head_arn_dest, t2_next_arn_dest;
	phys_reg_t t1_head_prn_dest, t1_next_prn_dest, t2_head_prn_dest, t2_next_prn_dest;

	rob_thread_queue #(.ROB_DEPTH(ROB_DEPTH), .THREAD_ID(0)) u_queue_t1 (
		.clock, .reset, .push_count(t1_push_count),
		.inst1_pc, .inst2_pc, .inst1_arn_dest, .inst2_arn_dest,
		.inst1_prn_dest, .inst2_prn_dest, .inst1_is_branch, .inst2_is_branch,
		.fu1_executed, .fu2_executed, .fu1_rob_tag, .fu2_rob_tag,
		.fu1_mispredict, .fu2_mispredict, .fu1_target_pc, .fu2_target_pc,
		.pop_count(t1_pop_count), .flush(t1_flush),
		.tail(t1_tail), .full(t1_queue_full),
		.head_ready(t1_head_ready), .next_ready(t1_next_ready),
		.head_pc(t1_head_pc), .next_pc(t1_next_pc),
		.head_target_pc(t1_head_target_pc), .next_target_pc(t1_next_target_pc),
		.head_is_branch(t1_head_is_branch), .next_is_branch(t1_next_is_branch),
		.head_mispredict(t1_head_mispredict), .next_mispredict(t1_next_mispredict),
		.head_arn_dest(t1_head_arn_dest), .next_arn_dest(t1_next_arn_dest),
		.head_prn_dest(t1_head_prn_dest), .next_prn_dest(t1_next_prn_dest)
	);

	rob_thread_queue #(.ROB_DEPTH(ROB_DEPTH), .THREAD_ID(1)) u_queue_t2 (
		.clock, .reset, .push_count(t2_push_count),
		.inst1_pc, .inst2_pc, .inst1_arn_dest, .inst2_arn_dest,
		.inst1_prn_dest, .inst2_prn_dest, .inst1_is_branch, .inst2_is_branch,
		.fu1_executed, .fu2_executed, .fu1_rob_tag, .fu2_rob_tag,
		.fu1_mispredict, .fu2_mispredict, .fu1_target_pc, .fu2_target_pc,
		.pop_count(t2_pop_count), .flush(t2_flush),
		.tail(t2_tail), .full(t2_queue_full),
		.head_ready(t2_head_ready), .next_ready(t2_next_ready),
		.head_pc(t2_head_pc), .next_pc(t2_next_pc),
		.head_target_pc(t2_head_target_pc), .next_target_pc(t2_next_target_pc),
		.head_is_branch(t2_head_is_branch), .next_is_branch(t2_next_is_branch),
		.head_mispredict(t2_head_mispredict), .next_mispredict(t2_next_mispredict),
		.head_arn_dest(t2_head_arn_dest), .next_arn_dest(t2_next_arn_dest),
		.head_prn_dest(t2_head_prn_dest), .next_prn_dest(t2_next_prn_dest)
	);

	rob_control #(.ROB_DEPTH(ROB_DEPTH)) u_control (.*);

endmodule

`default_nettype wire

//--- design/rob_types_pkg.sv
// entry field types and the default queue depth for the reorder buffer
`default_nettype none

package rob_types_pkg;

	typedef logic [63:0] pc_t;		// instruction and branch target pc
	typedef logic [4:0] arch_reg_t;		// architected register number
	typedef logic [5:0] phys_reg_t;		// 64 physical registers

	// entries per thread, a power of two and at least 4
	localparam int default_rob_depth = 16;

endpackage

`default_nettype wire

//--- dv/rob_tb_model.svh
// reference model of the two thread queues and the commit selection rule
`ifndef ROB_TB_MODEL_SVH
`define ROB_TB_MODEL_SVH

// index 0 is thread 1 and index 1 is thread 2, same as the tag thread bit
logic m_valid [2][DEPTH];
logic m_exec [2][DEPTH];
logic m_mis [2][DEPTH];
logic m_branch [2][DEPTH];
pc_t m_pc [2][DEPTH];
pc_t m_target [2][DEPTH];
arch_reg_t m_arn [2][DEPTH];
phys_reg_t m_prn [2][DEPTH];
logic [IDX_W-1:0] m_head [2];
logic [IDX_W-1:0] m_tail [2];
int m_count [2];

// expected commit of the current cycle, per slot
logic sel_valid [2];
logic sel_thread [2];
logic [IDX_W-1:0] sel_idx [2];

function automatic logic entry_ready(input logic t, input logic [IDX_W-1:0] i);
	return m_valid[t][i] && m_exec[t][i];
endfunction

function automatic logic bad_branch(input logic t, input logic [IDX_W-1:0] i);
	return m_branch[t][i] && m_mis[t][i];
endfunction

function automatic logic is_full(input logic t);
	return DEPTH - m_count[t] < 2;	// fewer than two free entries
endfunction

// empties one thread, tail falls back onto the head
task automatic clear_thread(input logic t);
	int k;
	for (k = 0; k < DEPTH; k++)
	begin
		m_valid[t][IDX_W'(k)] = 1'b0;
		m_exec[t][IDX_W'(k)] = 1'b0;
	end
	m_tail[t] = m_head[t];
	m_count[t] = 0;
endtask

task automatic reset_model();
	m_head[0] = '0;
	m_head[1] = '0;
	clear_thread(1'b0);
	clear_thread(1'b1);
endtask

// thread 1 head first; slot 2 prefers the same thread unless slot 1 mispredicted
task automatic select_commit();
	logic ft;
	logic [IDX_W-1:0] h;
	sel_valid[0] = 1'b0;
	sel_valid[1] = 1'b0;
	sel_thread[0] = 1'b0;
	sel_thread[1] = 1'b0;
	sel_idx[0] = '0;
	sel_idx[1] = '0;
	ft = !entry_ready(1'b0, m_head[0]);
	h = m_head[ft];
	if (entry_ready(ft, h))
	begin
		sel_valid[0] = 1'b1;
		sel_thread[0] = ft;
		sel_idx[0] = h;
		if (entry_ready(ft, h + IDX_W'(1)) && !bad_branch(ft, h))
		begin
			sel_valid[1] = 1'b1;
			sel_thread[1] = ft;
			sel_idx[1] = h + IDX_W'(1);
		end
		else if (!ft && entry_ready(1'b1, m_head[1]))
		begin
			sel_valid[1] = 1'b1;	// mixed pair
			sel_thread[1] = 1'b1;
			sel_idx[1] = m_head[1];
		end
	end
endtask

task automatic mark_executed(input logic [IDX_W:0] tag, input logic mis, input pc_t target);
	if (m_valid[tag[IDX_W]][tag[IDX_W-1:0]])
	begin
		m_exec[tag[IDX_W]][tag[IDX_W-1:0]] = 1'b1;
		m_mis[tag[IDX_W]][tag[IDX_W-1:0]] = mis;
		m_target[tag[IDX_W]][tag[IDX_W-1:0]] = target;
	end
endtask

task automatic write_entry(input logic t, input pc_t pc, input arch_reg_t arn,
	input phys_reg_t prn, input logic br);
	m_valid[t][m_tail[t]] = 1'b1;
	m_exec[t][m_tail[t]] = 1'b0;
	m_mis[t][m_tail[t]] = 1'b0;
	m_pc[t][m_tail[t]] = pc;
	m_arn[t][m_tail[t]] = arn;
	m_prn[t][m_tail[t]] = prn;
	m_branch[t][m_tail[t]] = br;
	m_tail[t] = m_tail[t] + IDX_W'(1);
endtask

task automatic advance_thread(input logic t, input logic [1:0] pop, input logic flush);
	logic [1:0] push;
	push = (is_thread1 != t) ? 2'(inst1_load) + 2'(inst2_load) : 2'd0;
	repeat (pop)
	begin
		m_valid[t][m_head[t]] = 1'b0;
		m_head[t] = m_head[t] + IDX_W'(1);
	end
	if (flush)
		clear_thread(t);	// a dispatch into the flushed thread is lost too
	else
	begin
		m_count[t] = m_count[t] + int'(push) - int'(pop);
		if (push != 2'd0)
			write_entry(t, inst1_pc, inst1_arn_dest, inst1_prn_dest, inst1_is_branch);
		if (push == 2'd2)
			write_entry(t, inst2_pc, inst2_arn_dest, inst2_prn_dest, inst2_is_branch);
	end
endtask

// state after the coming rising edge, from the current selection and inputs
task automatic apply_edge();
	logic [1:0] pop [2];
	logic flush [2];
	pop[0] = 2'd0;
	pop[1] = 2'd0;
	flush[0] = 1'b0;
	flush[1] = 1'b0;
	if (sel_valid[0])
	begin
		pop[sel_thread[0]] = pop[sel_thread[0]] + 2'd1;
		flush[sel_thread[0]] = flush[sel_thread[0]] || bad_branch(sel_thread[0], sel_idx[0]);
	end
	if (sel_valid[1])
	begin
		pop[sel_thread[1]] = pop[sel_thread[1]] + 2'd1;
		flush[sel_thread[1]] = flush[sel_thread[1]] || bad_branch(sel_thread[1], sel_idx[1]);
	end
	if (fu1_executed)
		mark_executed(fu1_rob_tag, fu1_mispredict, fu1_target_pc);
	if (fu2_executed)
		mark_executed(fu2_rob_tag, fu2_mispredict, fu2_target_pc);
	advance_thread(1'b0, pop[0], flush[0]);
	advance_thread(1'b1, pop[1], flush[1]);
endtask

`endif

//--- dv/tb_rob_top.sv
// testbench for the two-thread reorder buffer with clock, reset, random traffic, checks and watchdog
`timescale 1ns/10ps
`default_nettype none

module tb_rob_top;
	import rob_types_pkg::*;

	localparam int DEPTH = 16;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int CLOCK_PERIOD = 100;
	localparam int RESET_CYCLES = 2;
	localparam int NUM_CYCLES = 2000;
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CYCLES + 50) * CLOCK_PERIOD;

	logic clock = 1'b0;
	logic reset;
	logic is_thread1;
	pc_t inst1_pc, inst2_pc;
	arch_reg_t inst1_arn_dest, inst2_arn_dest;
	phys_reg_t inst1_prn_dest, inst2_prn_dest;
	logic inst1_is_branch, inst2_is_branch;
	logic inst1_load, inst2_load;
	logic fu1_executed, fu2_executed;
	logic [IDX_W:0] fu1_rob_tag, fu2_rob_tag;
	logic fu1_mispredict, fu2_mispredict;
	pc_t fu1_target_pc, fu2_target_pc;
	logic [IDX_W:0] inst1_rob_tag, inst2_rob_tag;
	logic commit1_valid, commit2_valid;
	pc_t commit1_pc, commit2_pc, commit1_target_pc, commit2_target_pc;
	logic commit1_is_branch, commit2_is_branch;
	logic commit1_mispredict, commit2_mispredict;
	arch_reg_t commit1_arn_dest, commit2_arn_dest;
	phys_reg_t commit1_prn_dest, commit2_prn_dest;
	logic commit1_is_thread1, commit2_is_thread1;
	logic t1_full, t2_full;

	integer seed = 49;
	int pc_seq;
	int n_commits;
	int n_mixed;
	int n_flushes;
	int cycle;

	`include "rob_tb_model.svh"

	rob_top #(.ROB_DEPTH(DEPTH)) u_dut (.*);

	always #(CLOCK_PERIOD / 2) clock = !clock;

	task automatic flag_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, expected);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first mismatch");
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("RESULT: FAIL");
		$fatal(1, "run aborted");
	endtask

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	task automatic clear_inputs();
		is_thread1 = 1'b1;
		inst1_pc = '0;
		inst2_pc = '0;
		inst1_arn_dest = '0;
		inst2_arn_dest = '0;
		inst1_prn_dest = '0;
		inst2_prn_dest = '0;
		inst1_is_branch = 1'b0;
		inst2_is_branch = 1'b0;
		inst1_load = 1'b0;
		inst2_load = 1'b0;
		fu1_executed = 1'b0;
		fu2_executed = 1'b0;
		fu1_rob_tag = '0;
		fu2_rob_tag = '0;
		fu1_mispredict = 1'b0;
		fu2_mispredict = 1'b0;
		fu1_target_pc = '0;
		fu2_target_pc = '0;
	endtask

	// completes a random in-flight entry that has not executed yet
	task automatic pick_completion(output logic done, output logic [IDX_W:0] tag,
		output logic mis, output pc_t target, input logic [IDX_W:0] other,
		input logic other_done);
		logic t;
		logic [IDX_W-1:0] idx;
		done = 1'b0;
		tag = '0;
		mis = 1'b0;
		target = {$random(seed), $random(seed)};
		t = 1'(rand_below(2));
		if (m_count[t] > 0 && rand_below(4) != 0)
		begin
			idx = m_head[t] + IDX_W'(rand_below(m_count[t]));
			if (!m_exec[t][idx] && !(other_done && other == {t, idx}))
			begin
				done = 1'b1;
				tag = {t, idx};
				mis = m_branch[t][idx] && rand_below(8) == 0;	// rare flushes
			end
		end
	endtask

	task automatic drive_inputs();
		logic t;
		int n;
		t = 1'(rand_below(2));
		n = is_full(t) ? 0 : rand_below(3);
		is_thread1 = !t;
		inst1_load = n > 0;
		inst2_load = n == 2;
		inst1_pc = 64'h8000_0000 + 64'(pc_seq) * 64'd4;	// unique per slot
		inst2_pc = inst1_pc + 64'd4;
		pc_seq = pc_seq + 2;
		inst1_arn_dest = 5'(rand_below(32));
		inst2_arn_dest = 5'(rand_below(32));
		inst1_prn_dest = 6'(rand_below(64));
		inst2_prn_dest = 6'(rand_below(64));
		inst1_is_branch = rand_below(4) == 0;
		inst2_is_branch = rand_below(4) == 0;
		pick_completion(fu1_executed, fu1_rob_tag, fu1_mispredict, fu1_target_pc, '0, 1'b0);
		pick_completion(fu2_executed, fu2_rob_tag, fu2_mispredict, fu2_target_pc,
			fu1_rob_tag, fu1_executed);
	endtask

	task automatic verify_slot(input string name, input logic s, input logic is_t1,
		input pc_t pc, input pc_t target, input logic br, input logic mis,
		input arch_reg_t arn, input phys_reg_t prn);
		logic t;
		logic [IDX_W-1:0] i;
		t = sel_thread[s];
		i = sel_idx[s];
		a_thread: assert (is_t1 == !t)
			else flag_mismatch({name, "_is_thread1"}, 64'(is_t1), 64'(!t));
		a_pc: assert (pc == m_pc[t][i])
			else flag_mismatch({name, "_pc"}, pc, m_pc[t][i]);
		a_target: assert (target == m_target[t][i])
			else flag_mismatch({name, "_target_pc"}, target, m_target[t][i]);
		a_branch: assert (br == m_branch[t][i])
			else flag_mismatch({name, "_is_branch"}, 64'(br), 64'(m_branch[t][i]));
		a_mis: assert (mis == m_mis[t][i])
			else flag_mismatch({name, "_mispredict"}, 64'(mis), 64'(m_mis[t][i]));
		a_arn: assert (arn == m_arn[t][i])
			else flag_mismatch({name, "_arn_dest"}, 64'(arn), 64'(m_arn[t][i]));
		a_prn: assert (prn == m_prn[t][i])
			else flag_mismatch({name, "_prn_dest"}, 64'(prn), 64'(m_prn[t][i]));
		n_commits++;
		if (br && mis)
			n_flushes++;
	endtask

	task automatic compare_outputs();
		logic t;
		logic [IDX_W:0] exp_tag1;
		logic [IDX_W:0] exp_tag2;
		select_commit();
		t = !is_thread1;
		exp_tag1 = inst1_load ? {t, m_tail[t]} : '0;
		exp_tag2 = inst2_load ? {t, m_tail[t] + IDX_W'(1)} : '0;
		a_tag1: assert (inst1_rob_tag == exp_tag1)
			else flag_mismatch("inst1_rob_tag", 64'(inst1_rob_tag), 64'(exp_tag1));
		a_tag2: assert (inst2_rob_tag == exp_tag2)
			else flag_mismatch("inst2_rob_tag", 64'(inst2_rob_tag), 64'(exp_tag2));
		a_full1: assert (t1_full == is_full(1'b0))
			else flag_mismatch("t1_full", 64'(t1_full), 64'(is_full(1'b0)));
		a_full2: assert (t2_full == is_full(1'b1))
			else flag_mismatch("t2_full", 64'(t2_full), 64'(is_full(1'b1)));
		a_valid1: assert (commit1_valid == sel_valid[0])
			else flag_mismatch("commit1_valid", 64'(commit1_valid), 64'(sel_valid[0]));
		a_valid2: assert (commit2_valid == sel_valid[1])
			else flag_mismatch("commit2_valid", 64'(commit2_valid), 64'(sel_valid[1]));
		if (sel_valid[0])
			verify_slot("commit1", 1'b0, commit1_is_thread1, commit1_pc, commit1_target_pc,
				commit1_is_branch, commit1_mispredict, commit1_arn_dest, commit1_prn_dest);
		if (sel_valid[1])
			verify_slot("commit2", 1'b1, commit2_is_thread1, commit2_pc, commit2_target_pc,
				commit2_is_branch, commit2_mispredict, commit2_arn_dest, commit2_prn_dest);
		if (sel_valid[1] && sel_thread[1] != sel_thread[0])
			n_mixed++;
	endtask

	a_pair_order: assert property (@(posedge clock) disable iff (reset)
		commit2_valid |-> commit1_valid)
		else abort_run("commit slot 2 valid while slot 1 is idle");

	// thread 2 in slot 1 means thread 1 had nothing ready
	a_t1_priority: assert property (@(posedge clock) disable iff (reset)
		(commit2_valid && !commit1_is_thread1) |-> !commit2_is_thread1)
		else abort_run("thread 1 entry committed behind a thread 2 entry");

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("timeout: the test loop did not finish in time");
	end

	initial
	begin
		reset = 1'b1;
		pc_seq = 0;
		n_commits = 0;
		n_mixed = 0;
		n_flushes = 0;
		clear_inputs();
		reset_model();
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;
		a_reset_quiet: assert (!commit1_valid && !commit2_valid && !t1_full && !t2_full)
			else abort_run("commit valid or full flag set in the first cycle after reset");
		for (cycle = 0; cycle < NUM_CYCLES; cycle++)
		begin
			drive_inputs();
			@(negedge clock);
			compare_outputs();
			apply_edge();
			@(posedge clock);
			#1;
		end
		$display("%0d commits, %0d mixed pairs, %0d flushes", n_commits, n_mixed, n_flushes);
		if (n_commits > 0 && n_mixed > 0 && n_flushes > 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
			abort_run("traffic never produced commits, mixed pairs and flushes");
	end

endmodule

`default_nettype wire

//--- rob.f
+incdir+dv
design/rob_types_pkg.sv
design/rob_ctrl_pkg.sv
design/rob_thread_queue.sv
design/rob_control.sv
design/rob_top.sv
dv/tb_rob_top.sv

//--- run_sim.sh
#!/bin/sh
# compile the reorder buffer testbench with Verilator and run it
# the exit status is the simulator's, nonzero on any failure

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rob_top -f rob.f -o sim_rob
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_rob
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0
